// File: verilog/qsim_pkg.sv
package qsim_pkg;

  // --------------------------------------------------
  // amplitude format
  // --------------------------------------------------

  // one real or imaginary component, Q1.14
  localparam int AMP_W     = 16;
  localparam int FRAC_BITS = 14;

  // packed memory word, real part in the upper half
  localparam int WORD_W = 32;

  // full product plus growth over the longest row
  localparam int ACC_W = 40;

  typedef logic signed [AMP_W-1:0] amp_t;
  typedef logic [WORD_W-1:0]       word_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // --------------------------------------------------
  // sequencer states
  // --------------------------------------------------

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    LOAD,
    ROWS,
    DRAIN
  } ctrl_state_t;

endpackage

// File: verilog/qsim_ctrl.sv
`timescale 1ns/1ps

module qsim_ctrl #(
  parameter int MAX_QUBITS = 4,
  parameter int MAX_GATES  = 4,
  localparam int MAX_N = 2 ** MAX_QUBITS,
  localparam int IN_AW = $clog2(MAX_N + 1),
  localparam int GT_AW = $clog2(MAX_GATES * MAX_N * MAX_N),
  localparam int SP_AW = MAX_QUBITS + 1
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                dut_valid,
  output logic                dut_ready,
  output logic [IN_AW-1:0]    q_state_input_sram_read_address,
  input  qsim_pkg::word_t     q_state_input_sram_read_data,
  output logic [GT_AW-1:0]    q_gates_sram_read_address,
  output logic [SP_AW-1:0]    scratchpad_sram_read_address,
  input  qsim_pkg::word_t     scratchpad_sram_read_data,
  output qsim_pkg::word_t     state_amp,
  output logic                term_valid,
  output logic                term_first,
  output logic                term_last,
  output logic [SP_AW-1:0]    wr_addr,
  output logic                wr_to_output
);

  localparam int QW = $clog2(MAX_QUBITS + 1);
  localparam int GW = $clog2(MAX_GATES + 1);

  qsim_pkg::ctrl_state_t state;

  logic [QW-1:0]         q_reg;
  logic [GW-1:0]         m_reg;
  logic [GW-1:0]         gate_cnt;
  logic [MAX_QUBITS-1:0] col_cnt;
  logic [MAX_QUBITS-1:0] row_cnt;
  logic [MAX_QUBITS-1:0] n_m1;
  logic [1:0]            drain_cnt;
  logic [GT_AW-1:0]      gate_addr;
  logic                  row_end;
  logic                  gate_end;
  logic                  last_gate;

  // N-1 as a mask of Q ones
  assign n_m1      = ~({MAX_QUBITS{1'b1}} << q_reg);
  assign row_end   = (col_cnt == n_m1);
  assign gate_end  = row_end && (row_cnt == n_m1);
  assign last_gate = (gate_cnt == m_reg - 1'b1);

  // --------------------------------------------------
  // job sequencer
  // --------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state     <= qsim_pkg::IDLE;
      dut_ready <= 1'b1;
      q_reg     <= '0;
      m_reg     <= '0;
      gate_cnt  <= '0;
      col_cnt   <= '0;
      row_cnt   <= '0;
      drain_cnt <= '0;
      gate_addr <= '0;
    end
    else
    begin
      case (state)
        qsim_pkg::IDLE:
        begin
          if (dut_valid)
          begin
            state     <= qsim_pkg::HEADER;
            dut_ready <= 1'b0;
          end
        end
        qsim_pkg::HEADER:
        begin
          state <= qsim_pkg::LOAD;
        end
        qsim_pkg::LOAD:
        begin
          // Q in the upper half, M in the lower half
          q_reg     <= q_state_input_sram_read_data[qsim_pkg::WORD_W/2 +: QW];
          m_reg     <= q_state_input_sram_read_data[0 +: GW];
          gate_cnt  <= '0;
          col_cnt   <= '0;
          row_cnt   <= '0;
          gate_addr <= '0;
          state     <= qsim_pkg::ROWS;
        end
        qsim_pkg::ROWS:
        begin
          // gates are row-major and back to back, so one running address
          gate_addr <= gate_addr + 1'b1;
          col_cnt   <= row_end ? '0 : col_cnt + 1'b1;
          if (row_end)
            row_cnt <= gate_end ? '0 : row_cnt + 1'b1;
          if (gate_end)
          begin
            drain_cnt <= '0;
            state     <= qsim_pkg::DRAIN;
          end
        end
        qsim_pkg::DRAIN:
        begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'd2)
          begin
            if (last_gate)
            begin
              state     <= qsim_pkg::IDLE;
              dut_ready <= 1'b1;
            end
            else
            begin
              gate_cnt <= gate_cnt + 1'b1;
              state    <= qsim_pkg::ROWS;
            end
          end
        end
        default:
        begin
          state <= qsim_pkg::IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // read addresses and operand select
  // --------------------------------------------------

  // header sits at address 0, amplitudes from 1
  assign q_state_input_sram_read_address =
    (state == qsim_pkg::ROWS) ? IN_AW'(col_cnt) + IN_AW'(1) : '0;
  assign q_gates_sram_read_address = gate_addr;

  // previous gate's region
  assign scratchpad_sram_read_address = {~gate_cnt[0], col_cnt};

  // gate count is stable from issue to data return
  assign state_amp = (gate_cnt == '0) ? q_state_input_sram_read_data
                                      : scratchpad_sram_read_data;

  // strobes and tags line up with the returning read data
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      term_valid   <= 1'b0;
      term_first   <= 1'b0;
      term_last    <= 1'b0;
      wr_addr      <= '0;
      wr_to_output <= 1'b0;
    end
    else
    begin
      term_valid   <= (state == qsim_pkg::ROWS);
      term_first   <= (state == qsim_pkg::ROWS) && (col_cnt == '0);
      term_last    <= (state == qsim_pkg::ROWS) && row_end;
      wr_addr      <= {gate_cnt[0], row_cnt};
      wr_to_output <= last_gate;
    end
  end

endmodule

// File: verilog/real_mac.sv
`timescale 1ns/1ps

module real_mac (
  input  logic            clk,
  input  logic            reset_n,
  input  qsim_pkg::word_t gate_amp,
  input  qsim_pkg::word_t state_amp,
  input  logic            term_valid,
  input  logic            term_first,
  output qsim_pkg::acc_t  real_sum
);

  qsim_pkg::amp_t gr;
  qsim_pkg::amp_t gi;
  qsim_pkg::amp_t sr;
  qsim_pkg::amp_t si;

  logic signed [2*qsim_pkg::AMP_W-1:0] p_rr;
  logic signed [2*qsim_pkg::AMP_W-1:0] p_ii;
  qsim_pkg::acc_t                      term;

  assign gr = gate_amp[qsim_pkg::WORD_W-1 -: qsim_pkg::AMP_W];
  assign gi = gate_amp[qsim_pkg::AMP_W-1:0];
  assign sr = state_amp[qsim_pkg::WORD_W-1 -: qsim_pkg::AMP_W];
  assign si = state_amp[qsim_pkg::AMP_W-1:0];

  // br*sr - bi*si
  assign p_rr = gr * sr;
  assign p_ii = gi * si;
  assign term = qsim_pkg::acc_t'(p_rr) - qsim_pkg::acc_t'(p_ii);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      real_sum <= '0;
    else if (term_valid)
      real_sum <= term_first ? term : real_sum + term;
  end

endmodule

// File: verilog/imag_mac.sv
`timescale 1ns/1ps

module imag_mac (
  input  logic            clk,
  input  logic            reset_n,
  input  qsim_pkg::word_t gate_amp,
  input  qsim_pkg::word_t state_amp,
  input  logic            term_valid,
  input  logic            term_first,
  output qsim_pkg::acc_t  imag_sum
);

  qsim_pkg::amp_t gr;
  qsim_pkg::amp_t gi;
  qsim_pkg::amp_t sr;
  qsim_pkg::amp_t si;

  logic signed [2*qsim_pkg::AMP_W-1:0] p_ri;
  logic signed [2*qsim_pkg::AMP_W-1:0] p_ir;
  qsim_pkg::acc_t                      term;

  assign gr = gate_amp[qsim_pkg::WORD_W-1 -: qsim_pkg::AMP_W];
  assign gi = gate_amp[qsim_pkg::AMP_W-1:0];
  assign sr = state_amp[qsim_pkg::WORD_W-1 -: qsim_pkg::AMP_W];
  assign si = state_amp[qsim_pkg::AMP_W-1:0];

  // cross terms br*si + bi*sr
  assign p_ri = gr * si;
  assign p_ir = gi * sr;
  assign term = qsim_pkg::acc_t'(p_ri) + qsim_pkg::acc_t'(p_ir);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      imag_sum <= '0;
    else if (term_valid)
      imag_sum <= term_first ? term : imag_sum + term;
  end

endmodule

// File: verilog/amp_writer.sv
`timescale 1ns/1ps

module amp_writer #(
  parameter int MAX_QUBITS = 4,
  localparam int SP_AW = MAX_QUBITS + 1
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  qsim_pkg::acc_t        real_sum,
  input  qsim_pkg::acc_t        imag_sum,
  input  logic                  term_last,
  input  logic [SP_AW-1:0]      wr_addr,
  input  logic                  wr_to_output,
  output logic                  scratchpad_sram_write_enable,
  output logic [SP_AW-1:0]      scratchpad_sram_write_address,
  output qsim_pkg::word_t       scratchpad_sram_write_data,
  output logic                  q_state_output_sram_write_enable,
  output logic [MAX_QUBITS-1:0] q_state_output_sram_write_address,
  output qsim_pkg::word_t       q_state_output_sram_write_data
);

  localparam qsim_pkg::acc_t SAT_HI = qsim_pkg::acc_t'((1 << (qsim_pkg::AMP_W - 1)) - 1);
  localparam qsim_pkg::acc_t SAT_LO = -SAT_HI - 1;

  logic             last_d;
  logic             to_out_d;
  logic [SP_AW-1:0] addr_d;
  logic [SP_AW-1:0] addr_q;
  qsim_pkg::word_t  word_q;

  // drop the fraction, clamp to the component range
  function automatic qsim_pkg::amp_t saturate(input qsim_pkg::acc_t v);
    qsim_pkg::acc_t s;
    s = v >>> qsim_pkg::FRAC_BITS;
    if (s > SAT_HI)
      s = SAT_HI;
    else if (s < SAT_LO)
      s = SAT_LO;
    return qsim_pkg::amp_t'(s);
  endfunction

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      last_d                           <= 1'b0;
      to_out_d                         <= 1'b0;
      addr_d                           <= '0;
      scratchpad_sram_write_enable     <= 1'b0;
      q_state_output_sram_write_enable <= 1'b0;
    end
    else
    begin
      last_d                           <= term_last;
      to_out_d                         <= wr_to_output;
      addr_d                           <= wr_addr;
      scratchpad_sram_write_enable     <= last_d && !to_out_d;
      q_state_output_sram_write_enable <= last_d && to_out_d;
    end
  end

  // sums are final while last_d is high, next row loads on this edge
  always_ff @(posedge clk)
  begin
    if (last_d)
    begin
      addr_q <= addr_d;
      word_q <= {saturate(real_sum), saturate(imag_sum)};
    end
  end

  assign scratchpad_sram_write_address     = addr_q;
  assign scratchpad_sram_write_data        = word_q;
  assign q_state_output_sram_write_address = addr_q[MAX_QUBITS-1:0];
  assign q_state_output_sram_write_data    = word_q;

endmodule

// File: verilog/qsim_top.sv
`timescale 1ns/1ps

module qsim_top #(
  parameter int MAX_QUBITS = 4,
  parameter int MAX_GATES  = 4,
  localparam int MAX_N = 2 ** MAX_QUBITS,
  localparam int IN_AW = $clog2(MAX_N + 1),
  localparam int GT_AW = $clog2(MAX_GATES * MAX_N * MAX_N),
  localparam int SP_AW = MAX_QUBITS + 1
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  dut_valid,
  output logic                  dut_ready,

  // input state memory
  output logic [IN_AW-1:0]      q_state_input_sram_read_address,
  input  qsim_pkg::word_t       q_state_input_sram_read_data,

  // gate memory
  output logic [GT_AW-1:0]      q_gates_sram_read_address,
  input  qsim_pkg::word_t       q_gates_sram_read_data,

  // scratchpad, two regions of MAX_N
  output logic [SP_AW-1:0]      scratchpad_sram_read_address,
  input  qsim_pkg::word_t       scratchpad_sram_read_data,
  output logic                  scratchpad_sram_write_enable,
  output logic [SP_AW-1:0]      scratchpad_sram_write_address,
  output qsim_pkg::word_t       scratchpad_sram_write_data,

  // output state memory
  output logic                  q_state_output_sram_write_enable,
  output logic [MAX_QUBITS-1:0] q_state_output_sram_write_address,
  output qsim_pkg::word_t       q_state_output_sram_write_data
);

  qsim_pkg::word_t  state_amp;
  logic             term_valid;
  logic             term_first;
  logic             term_last;
  logic [SP_AW-1:0] wr_addr;
  logic             wr_to_output;
  qsim_pkg::acc_t   real_sum;
  qsim_pkg::acc_t   imag_sum;

  qsim_ctrl #(
    .MAX_QUBITS (MAX_QUBITS),
    .MAX_GATES  (MAX_GATES)
  ) ctrl_i (
    .clk                             (clk),
    .reset_n                         (reset_n),
    .dut_valid                       (dut_valid),
    .dut_ready                       (dut_ready),
    .q_state_input_sram_read_address (q_state_input_sram_read_address),
    .q_state_input_sram_read_data    (q_state_input_sram_read_data),
    .q_gates_sram_read_address       (q_gates_sram_read_address),
    .scratchpad_sram_read_address    (scratchpad_sram_read_address),
    .scratchpad_sram_read_data       (scratchpad_sram_read_data),
    .state_amp                       (state_amp),
    .term_valid                      (term_valid),
    .term_first                      (term_first),
    .term_last                       (term_last),
    .wr_addr                         (wr_addr),
    .wr_to_output                    (wr_to_output)
  );

  // real and imaginary sums side by side
  real_mac real_mac_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .gate_amp   (q_gates_sram_read_data),
    .state_amp  (state_amp),
    .term_valid (term_valid),
    .term_first (term_first),
    .real_sum   (real_sum)
  );

  imag_mac imag_mac_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .gate_amp   (q_gates_sram_read_data),
    .state_amp  (state_amp),
    .term_valid (term_valid),
    .term_first (term_first),
    .imag_sum   (imag_sum)
  );

  amp_writer #(
    .MAX_QUBITS (MAX_QUBITS)
  ) writer_i (
    .clk                               (clk),
    .reset_n                           (reset_n),
    .real_sum                          (real_sum),
    .imag_sum                          (imag_sum),
    .term_last                         (term_last),
    .wr_addr                           (wr_addr),
    .wr_to_output                      (wr_to_output),
    .scratchpad_sram_write_enable      (scratchpad_sram_write_enable),
    .scratchpad_sram_write_address     (scratchpad_sram_write_address),
    .scratchpad_sram_write_data        (scratchpad_sram_write_data),
    .q_state_output_sram_write_enable  (q_state_output_sram_write_enable),
    .q_state_output_sram_write_address (q_state_output_sram_write_address),
    .q_state_output_sram_write_data    (q_state_output_sram_write_data)
  );

endmodule

// File: tests/qsim_chk.sv
`timescale 1ns/1ps

module qsim_chk (
  input logic            clk,
  input logic            reset_n,
  input logic            dut_valid,
  input logic            dut_ready,
  input logic            scratchpad_sram_write_enable,
  input logic            q_state_output_sram_write_enable,
  input qsim_pkg::word_t q_state_input_sram_read_data
);

  logic start;

  // job accepted on this edge
  assign start = dut_valid && dut_ready;

  // --------------------------------------------------
  // properties
  // --------------------------------------------------

  ready_low_on_write: assert property (
    @(posedge clk) disable iff (!reset_n)
    (scratchpad_sram_write_enable || q_state_output_sram_write_enable) |-> !dut_ready
  ) else $error("write enable high while dut_ready is high");

  one_write_target: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(scratchpad_sram_write_enable && q_state_output_sram_write_enable)
  ) else $error("scratchpad and output written in the same cycle");

  // header data returns two edges after the start, M in the lower half
  header_m_nonzero: assert property (
    @(posedge clk) disable iff (!reset_n)
    $past(start, 2) |-> (q_state_input_sram_read_data[qsim_pkg::WORD_W/2-1:0] != '0)
  ) else $error("header gate count is zero");

endmodule

// File: tests/qsim_tb.sv
`timescale 1ns/1ps

module qsim_tb;

  localparam int MAX_QUBITS = 4;
  localparam int MAX_GATES  = 4;
  localparam int MAX_N      = 2 ** MAX_QUBITS;
  localparam int IN_AW      = $clog2(MAX_N + 1);
  localparam int GT_AW      = $clog2(MAX_GATES * MAX_N * MAX_N);
  localparam int SP_AW      = MAX_QUBITS + 1;
  localparam int CLK_PERIOD = 8;
  localparam int NJOBS      = 6;

  typedef enum int {G_IDENT, G_SWAP, G_SCALE, G_RAND} gate_kind_t;
  typedef enum int {S_RAND, S_BIG} state_kind_t;

  // --------------------------------------------------
  // job table
  // --------------------------------------------------

  int          job_q [NJOBS] = '{1, 2, 3, 2, 4, 1};
  int          job_m [NJOBS] = '{1, 1, 3, 1, 2, 2};
  gate_kind_t  job_gate [NJOBS][MAX_GATES] = '{
    '{G_IDENT, G_IDENT, G_IDENT, G_IDENT},
    '{G_SWAP,  G_IDENT, G_IDENT, G_IDENT},
    '{G_RAND,  G_RAND,  G_RAND,  G_IDENT},
    '{G_SCALE, G_IDENT, G_IDENT, G_IDENT},
    '{G_RAND,  G_SWAP,  G_IDENT, G_IDENT},
    '{G_SWAP,  G_IDENT, G_IDENT, G_IDENT}
  };
  state_kind_t job_state [NJOBS] = '{S_RAND, S_RAND, S_RAND, S_BIG, S_RAND, S_RAND};

  logic                  clk;
  logic                  reset_n;
  logic                  dut_valid;
  logic                  dut_ready;
  logic [IN_AW-1:0]      in_raddr;
  qsim_pkg::word_t       in_rdata = '0;
  logic [GT_AW-1:0]      gate_raddr;
  qsim_pkg::word_t       gate_rdata = '0;
  logic [SP_AW-1:0]      sp_raddr;
  qsim_pkg::word_t       sp_rdata = '0;
  logic                  sp_we;
  logic [SP_AW-1:0]      sp_waddr;
  qsim_pkg::word_t       sp_wdata;
  logic                  out_we;
  logic [MAX_QUBITS-1:0] out_waddr;
  qsim_pkg::word_t       out_wdata;

  qsim_pkg::word_t in_mem [2**IN_AW];
  qsim_pkg::word_t gate_mem [2**GT_AW];
  qsim_pkg::word_t sp_mem [2**SP_AW];
  qsim_pkg::word_t out_mem [MAX_N];
  int              sp_writes = 0;
  int              out_writes = 0;
  qsim_pkg::amp_t  exp_re [MAX_N];
  qsim_pkg::amp_t  exp_im [MAX_N];
  logic [31:0]     lfsr = 32'he33b3b46;

  qsim_top #(
    .MAX_QUBITS (MAX_QUBITS),
    .MAX_GATES  (MAX_GATES)
  ) qsim_top_i (
    .clk                               (clk),
    .reset_n                           (reset_n),
    .dut_valid                         (dut_valid),
    .dut_ready                         (dut_ready),
    .q_state_input_sram_read_address   (in_raddr),
    .q_state_input_sram_read_data      (in_rdata),
    .q_gates_sram_read_address         (gate_raddr),
    .q_gates_sram_read_data            (gate_rdata),
    .scratchpad_sram_read_address      (sp_raddr),
    .scratchpad_sram_read_data         (sp_rdata),
    .scratchpad_sram_write_enable      (sp_we),
    .scratchpad_sram_write_address     (sp_waddr),
    .scratchpad_sram_write_data        (sp_wdata),
    .q_state_output_sram_write_enable  (out_we),
    .q_state_output_sram_write_address (out_waddr),
    .q_state_output_sram_write_data    (out_wdata)
  );

  bind qsim_top qsim_chk chk_i (
    .clk                              (clk),
    .reset_n                          (reset_n),
    .dut_valid                        (dut_valid),
    .dut_ready                        (dut_ready),
    .scratchpad_sram_write_enable     (scratchpad_sram_write_enable),
    .q_state_output_sram_write_enable (q_state_output_sram_write_enable),
    .q_state_input_sram_read_data     (q_state_input_sram_read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // memory models, one cycle read latency
  // --------------------------------------------------

  always @(posedge clk)
  begin
    in_rdata   <= in_mem[in_raddr];
    gate_rdata <= gate_mem[gate_raddr];
    sp_rdata   <= sp_mem[sp_raddr];
    if (sp_we)
    begin
      sp_mem[sp_waddr] <= sp_wdata;
      sp_writes        <= sp_writes + 1;
    end
  end

  // fresh pattern in the output memory at each job start
  always @(posedge clk)
  begin
    if (dut_valid && dut_ready)
    begin
      for (int a = 0; a < MAX_N; a++)
        out_mem[a] <= {16'hbad0, 16'(a)};
    end
    else if (out_we)
    begin
      out_mem[out_waddr] <= out_wdata;
      out_writes         <= out_writes + 1;
    end
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // signed random component of nbits
  function automatic qsim_pkg::amp_t rand_comp(input int nbits);
    logic [31:0] v;
    v = take_bits(nbits) << (32 - nbits);
    return qsim_pkg::amp_t'($signed(v) >>> (32 - nbits));
  endfunction

  // magnitude around 1.5 with random sign
  function automatic qsim_pkg::amp_t big_comp();
    qsim_pkg::amp_t mag;
    mag = qsim_pkg::amp_t'(16'h6000 | 16'(take_bits(12)));
    return take_bits(1) ? -mag : mag;
  endfunction

  // drop the fraction bits, clamp to the component range
  function automatic qsim_pkg::amp_t scale_down(input longint v);
    longint s;
    longint hi;
    hi = (longint'(1) << (qsim_pkg::AMP_W - 1)) - 1;
    s  = v >>> qsim_pkg::FRAC_BITS;
    if (s > hi)
      s = hi;
    else if (s < -hi - 1)
      s = -hi - 1;
    return qsim_pkg::amp_t'(s);
  endfunction

  function automatic qsim_pkg::word_t gate_entry(input gate_kind_t kind, input int r,
                                                 input int c, input int n);
    qsim_pkg::amp_t one;
    qsim_pkg::amp_t re;
    qsim_pkg::amp_t im;
    one = qsim_pkg::amp_t'(1 << qsim_pkg::FRAC_BITS);
    case (kind)
      G_IDENT:
        return (r == c) ? {one, 16'h0000} : '0;
      G_SWAP:
        return (c == n - 1 - r) ? {one, 16'h0000} : '0;
      // just under 2.0
      G_SCALE:
        return (r == c) ? {16'h7fff, 16'h0000} : '0;
      default:
      begin
        re = rand_comp(13);
        im = rand_comp(13);
        return {re, im};
      end
    endcase
  endfunction

  // --------------------------------------------------
  // job setup and golden model
  // --------------------------------------------------

  task automatic build_job(input int j);
    int              n;
    int              base;
    qsim_pkg::amp_t  cur_re [MAX_N];
    qsim_pkg::amp_t  cur_im [MAX_N];
    qsim_pkg::amp_t  gr;
    qsim_pkg::amp_t  gi;
    longint          acc_re;
    longint          acc_im;
    qsim_pkg::word_t w;
    n = 1 << job_q[j];
    in_mem[0] = {16'(job_q[j]), 16'(job_m[j])};
    for (int a = 1; a < 2 ** IN_AW; a++)
      in_mem[a] = {16'h1e00, 16'(a)};
    for (int i = 0; i < n; i++)
    begin
      cur_re[i]    = (job_state[j] == S_BIG) ? big_comp() : rand_comp(14);
      cur_im[i]    = (job_state[j] == S_BIG) ? big_comp() : rand_comp(14);
      in_mem[i + 1] = {cur_re[i], cur_im[i]};
    end
    for (int a = 0; a < 2 ** GT_AW; a++)
      gate_mem[a] = {16'h6a7e, 16'(a)};
    for (int g = 0; g < job_m[j]; g++)
    begin
      base = g * n * n;
      for (int r = 0; r < n; r++)
        for (int c = 0; c < n; c++)
          gate_mem[base + r * n + c] = gate_entry(job_gate[j][g], r, c, n);
      // complex matrix-vector product, full precision until the row ends
      for (int r = 0; r < n; r++)
      begin
        acc_re = 0;
        acc_im = 0;
        for (int c = 0; c < n; c++)
        begin
          w      = gate_mem[base + r * n + c];
          gr     = qsim_pkg::amp_t'(w[31:16]);
          gi     = qsim_pkg::amp_t'(w[15:0]);
          acc_re += longint'(gr) * longint'(cur_re[c]) - longint'(gi) * longint'(cur_im[c]);
          acc_im += longint'(gr) * longint'(cur_im[c]) + longint'(gi) * longint'(cur_re[c]);
        end
        exp_re[r] = scale_down(acc_re);
        exp_im[r] = scale_down(acc_im);
      end
      for (int r = 0; r < n; r++)
      begin
        cur_re[r] = exp_re[r];
        cur_im[r] = exp_im[r];
      end
    end
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_amp(input string name, input qsim_pkg::amp_t got,
                           input qsim_pkg::amp_t exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      fail_run("amplitude mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      fail_run("write count mismatch");
    end
  endtask

  // watchdog sized from the job table
  initial
  begin
    int total;
    total = 10;
    for (int j = 0; j < NJOBS; j++)
      total += job_m[j] * ((1 << (2 * job_q[j])) + 4) + 12;
    #(2 * total * CLK_PERIOD + 1000);
    fail_run("watchdog expired before all jobs finished");
  end

  initial
  begin
    int n;
    int sp_start;
    int out_start;
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    for (int j = 0; j < NJOBS; j++)
    begin
      build_job(j);
      n         = 1 << job_q[j];
      sp_start  = sp_writes;
      out_start = out_writes;
      @(posedge clk);
      #1;
      if (!dut_ready)
        fail_run("dut_ready was low before the job started");
      dut_valid = 1'b1;
      @(posedge clk);
      #1;
      dut_valid = 1'b0;
      if (dut_ready)
        fail_run("dut_ready did not fall after dut_valid");
      while (!dut_ready)
      begin
        @(posedge clk);
        #1;
      end
      for (int i = 0; i < n; i++)
      begin
        check_amp($sformatf("q_state_output_sram_write_data[%0d] real", i),
                  qsim_pkg::amp_t'(out_mem[i][31:16]), exp_re[i]);
        check_amp($sformatf("q_state_output_sram_write_data[%0d] imag", i),
                  qsim_pkg::amp_t'(out_mem[i][15:0]), exp_im[i]);
      end
      check_count("q_state_output_sram_write_enable count", out_writes - out_start, n);
      check_count("scratchpad_sram_write_enable count", sp_writes - sp_start,
                  (job_m[j] - 1) * n);
      repeat (3) @(posedge clk);
      #1;
      if (!dut_ready)
        fail_run("dut_ready fell after the job ended");
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: list.f
verilog/qsim_pkg.sv
verilog/qsim_ctrl.sv
verilog/real_mac.sv
verilog/imag_mac.sv
verilog/amp_writer.sv
verilog/qsim_top.sv
tests/qsim_chk.sv
tests/qsim_tb.sv

// File: run.sh
#!/bin/sh

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module qsim_tb -f list.f -o qsim_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/qsim_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "CHECKS FAILED" "$log"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
